/* build.f */
+incdir+verification
source/bp_cfg_pkg.sv
source/bp_entry_pkg.sv
source/btb_array.sv
source/bht_array.sv
source/return_stack.sv
source/bp_predict.sv
source/bp_update.sv
source/branch_predictor.sv
verification/tb_clock_gen.sv
verification/branch_predictor_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module branch_predictor_tb \
   -o branch_predictor_sim

./obj_dir/branch_predictor_sim

/* source/bht_array.sv */
`timescale 1ns/1ps

module bht_array
   import bp_cfg_pkg::*;
   import bp_entry_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  bht_idx_t rd_idx,
   input  logic     mp_en,
   input  bht_idx_t mp_idx,
   input  ctr_t     mp_ctr,
   input  logic     br_en,
   input  bht_idx_t br_idx,
   input  ctr_t     br_ctr,
   output ctr_t     rd_ctr
);

   ctr_t ctr_q [BHT_DEPTH];
   logic br_wins;

   // same index from both ports, commit data goes in
   assign br_wins = br_en & (br_idx == mp_idx);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < BHT_DEPTH; i++) begin
            ctr_q[i] <= '0;
         end
      end else begin
         if (mp_en && !br_wins) begin
            ctr_q[mp_idx] <= mp_ctr;   // execute stage
         end
         if (br_en) begin
            ctr_q[br_idx] <= br_ctr;   // commit
         end
      end
   end

   assign rd_ctr = ctr_q[rd_idx];

endmodule

/* source/bp_cfg_pkg.sv */
package bp_cfg_pkg;

   // --------------------------------------------------
   // sizes
   // --------------------------------------------------
   localparam int PC_W      = 31;               // halfword address, pc[31:1]
   localparam int BTB_IDX_W = 4;
   localparam int BTB_SETS  = 1 << BTB_IDX_W;
   localparam int BTB_TAG_W = 5;
   localparam int GHR_W     = 6;                // also the bht index width
   localparam int BHT_DEPTH = 1 << GHR_W;
   localparam int TOFF_W    = 12;
   localparam int RS_DEPTH  = 4;

   // --------------------------------------------------
   // address fields, bit 0 of a pc_t is pc[1]
   // --------------------------------------------------
   localparam int IDX_F0_LO = 0;                // pc[4:1]
   localparam int IDX_F1_LO = 4;                // pc[8:5]
   localparam int IDX_F2_LO = 8;                // pc[12:9]

   localparam int TAG_F0_LO = 12;               // pc[17:13]
   localparam int TAG_F1_LO = 17;               // pc[22:18]
   localparam int TAG_F2_LO = 22;               // pc[27:23]

   // --------------------------------------------------
   // vector types
   // --------------------------------------------------
   typedef logic [PC_W-1:0]      pc_t;
   typedef logic [BTB_IDX_W-1:0] btb_idx_t;
   typedef logic [BTB_TAG_W-1:0] btb_tag_t;
   typedef logic [GHR_W-1:0]     ghr_t;
   typedef logic [GHR_W-1:0]     bht_idx_t;
   typedef logic [TOFF_W-1:0]    toff_t;       // signed, in halfwords

endpackage

/* source/bp_entry_pkg.sv */
package bp_entry_pkg;

   import bp_cfg_pkg::*;

   // btb entry layout, valid in bit 0 and tag on top
   localparam int E_VALID   = 0;
   localparam int E_RET     = 1;
   localparam int E_CALL    = 2;
   localparam int E_PC4     = 3;
   localparam int E_TOFF_LO = 4;
   localparam int E_TOFF_HI = E_TOFF_LO + TOFF_W - 1;
   localparam int E_TAG_LO  = E_TOFF_HI + 1;
   localparam int E_TAG_HI  = E_TAG_LO + BTB_TAG_W - 1;
   localparam int ENTRY_W   = E_TAG_HI + 1;

   localparam int CTR_DIR   = 1;                // taken bit of a counter

   typedef logic [ENTRY_W-1:0] btb_entry_t;
   typedef logic [1:0]         ctr_t;          // {direction, strength}

   function automatic btb_idx_t btb_index_of(input pc_t pc);
      return pc[IDX_F0_LO +: BTB_IDX_W] ^ pc[IDX_F1_LO +: BTB_IDX_W] ^
             pc[IDX_F2_LO +: BTB_IDX_W];
   endfunction

   function automatic btb_tag_t btb_tag_of(input pc_t pc);
      return pc[TAG_F0_LO +: BTB_TAG_W] ^ pc[TAG_F1_LO +: BTB_TAG_W] ^
             pc[TAG_F2_LO +: BTB_TAG_W];
   endfunction

   // gshare, set index zero extended then folded with history
   function automatic bht_idx_t bht_index_of(input btb_idx_t idx, input ghr_t ghr);
      return {{(GHR_W-BTB_IDX_W){1'b0}}, idx} ^ ghr;
   endfunction

endpackage

/* source/bp_predict.sv */
`timescale 1ns/1ps

module bp_predict
   import bp_cfg_pkg::*;
   import bp_entry_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       fetch_req,
   input  pc_t        fetch_addr,
   input  logic       ic_hit,
   input  logic       bpred_disable,
   input  logic       flush,
   input  ghr_t       flush_ghr,
   input  btb_entry_t rd_way0,
   input  btb_entry_t rd_way1,
   input  logic       rd_lru,
   input  ctr_t       rd_ctr,
   input  pc_t        rs_top,
   input  logic       rs_top_valid,
   output btb_idx_t   btb_rd_idx,
   output bht_idx_t   bht_rd_idx,
   output logic       hit_en,
   output logic       hit_way0,
   output logic       rs_push,
   output logic       rs_pop,
   output pc_t        rs_push_addr,
   output logic       bp_hit_taken,
   output pc_t        bp_target,
   output logic       bp_valid,
   output logic       bp_way,
   output ctr_t       bp_hist,
   output logic       bp_ret,
   output ghr_t       bp_fghr
);

   btb_tag_t   fetch_tag;
   ghr_t       ghr_q;
   logic       match0, match1, hit;
   btb_entry_t sel;
   logic       sel_call, sel_ret, is_ret;
   logic       dir, taken;
   toff_t      sel_toff;
   pc_t        toff_ext;

   // --------------------------------------------------
   // lookup
   // --------------------------------------------------
   assign btb_rd_idx = btb_index_of(fetch_addr);
   assign fetch_tag  = btb_tag_of(fetch_addr);
   assign bht_rd_idx = bht_index_of(btb_rd_idx, ghr_q);

   assign match0 = fetch_req & rd_way0[E_VALID] & (rd_way0[E_TAG_HI:E_TAG_LO] == fetch_tag);
   assign match1 = fetch_req & rd_way1[E_VALID] & (rd_way1[E_TAG_HI:E_TAG_LO] == fetch_tag);
   assign hit    = match0 | match1;
   assign sel    = match0 ? rd_way0 : (match1 ? rd_way1 : '0);  // way 0 first

   assign sel_call = sel[E_CALL];
   assign sel_ret  = sel[E_RET];
   assign sel_toff = sel[E_TOFF_HI:E_TOFF_LO];
   assign is_ret   = sel_ret & ~sel_call;          // call+ret is a jump always

   // calls, returns and jumps are never in the counters, forced taken
   assign dir   = rd_ctr[CTR_DIR] | sel_call | sel_ret;
   assign taken = hit & dir;

   assign hit_en   = hit;
   assign hit_way0 = match0;

   // --------------------------------------------------
   // outputs and target
   // --------------------------------------------------
   assign bp_valid     = hit & ~bpred_disable;
   assign bp_hit_taken = taken & ~bpred_disable;
   assign bp_way       = hit ? ~match0 : rd_lru;
   assign bp_hist      = rd_ctr;
   assign bp_ret       = hit & is_ret;

   assign toff_ext  = {{(PC_W-TOFF_W){sel_toff[TOFF_W-1]}}, sel_toff};
   assign bp_target = (is_ret & rs_top_valid) ? rs_top : fetch_addr + toff_ext;

   assign rs_push      = bp_hit_taken & sel_call & ~sel_ret;
   assign rs_pop       = bp_hit_taken & is_ret;
   assign rs_push_addr = fetch_addr + (sel[E_PC4] ? pc_t'(2) : pc_t'(1));

   // fetch history, flush reload beats the shift
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ghr_q <= '0;
      end else if (flush) begin
         ghr_q <= flush_ghr;
      end else if (fetch_req && ic_hit && bp_valid) begin
         ghr_q <= {ghr_q[GHR_W-2:0], taken};
      end
   end

   assign bp_fghr = ghr_q;

endmodule

/* source/bp_update.sv */
`timescale 1ns/1ps

module bp_update
   import bp_cfg_pkg::*;
   import bp_entry_pkg::*;
(
   input  logic       mp_valid,
   input  logic       mp_ataken,
   input  pc_t        mp_pc,
   input  ghr_t       mp_fghr,
   input  logic       mp_way,
   input  toff_t      mp_toffset,
   input  logic       mp_pc4,
   input  logic       mp_call,
   input  logic       mp_ret,
   input  logic       mp_ja,
   input  logic       br_valid,
   input  pc_t        br_pc,
   input  ghr_t       br_fghr,
   input  logic       br_way,
   input  logic       br_error,
   output logic       btb_wr_en,
   output logic       btb_wr_way,
   output btb_idx_t   btb_wr_idx,
   output btb_entry_t btb_wr_entry,
   output logic       mp_lru_en,
   output btb_idx_t   mp_lru_idx,
   output logic       mp_lru_way,
   output logic       bht_mp_en,
   output bht_idx_t   bht_mp_idx,
   output logic       bht_br_en,
   output bht_idx_t   bht_br_idx
);

   btb_idx_t mp_idx;
   btb_idx_t br_idx;

   assign mp_idx = btb_index_of(mp_pc);
   assign br_idx = btb_index_of(br_pc);

   // --------------------------------------------------
   // btb write, error invalidate ahead of mispredict
   // --------------------------------------------------
   assign btb_wr_en  = br_error | (mp_valid & mp_ataken);
   assign btb_wr_way = br_error ? br_way : mp_way;
   assign btb_wr_idx = br_error ? br_idx : mp_idx;

   always_comb begin
      btb_wr_entry                      = '0;
      btb_wr_entry[E_TAG_HI:E_TAG_LO]   = btb_tag_of(mp_pc);
      btb_wr_entry[E_TOFF_HI:E_TOFF_LO] = mp_toffset;
      btb_wr_entry[E_PC4]               = mp_pc4;
      btb_wr_entry[E_CALL]              = mp_call | mp_ja;   // ja keeps both bits
      btb_wr_entry[E_RET]               = mp_ret | mp_ja;
      btb_wr_entry[E_VALID]             = ~br_error;
   end

   assign mp_lru_en  = mp_valid;
   assign mp_lru_idx = mp_idx;
   assign mp_lru_way = mp_way;

   // counters only for conditional branches
   assign bht_mp_en  = mp_valid & ~mp_call & ~mp_ret & ~mp_ja;
   assign bht_mp_idx = bht_index_of(mp_idx, mp_fghr);
   assign bht_br_en  = br_valid;
   assign bht_br_idx = bht_index_of(br_idx, br_fghr);

endmodule

/* source/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor
   import bp_cfg_pkg::*;
   import bp_entry_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   // fetch
   input  logic  fetch_req,
   input  pc_t   fetch_addr,
   input  logic  ic_hit,
   // execute mispredict
   input  logic  mp_valid,
   input  logic  mp_ataken,
   input  pc_t   mp_pc,
   input  ghr_t  mp_fghr,
   input  logic  mp_way,
   input  ctr_t  mp_hist,
   input  toff_t mp_toffset,
   input  logic  mp_pc4,
   input  logic  mp_call,
   input  logic  mp_ret,
   input  logic  mp_ja,
   // commit
   input  logic  br_valid,
   input  pc_t   br_pc,
   input  ghr_t  br_fghr,
   input  ctr_t  br_hist,
   input  logic  br_way,
   input  logic  br_error,
   // control
   input  logic  flush,
   input  ghr_t  flush_ghr,
   input  logic  bpred_disable,
   // prediction
   output logic  bp_hit_taken,
   output pc_t   bp_target,
   output logic  bp_valid,
   output logic  bp_way,
   output ctr_t  bp_hist,
   output logic  bp_ret,
   output ghr_t  bp_fghr
);

   // --------------------------------------------------
   // internal nets, named after the bp_predict and bp_update ports
   // --------------------------------------------------
   btb_idx_t   btb_rd_idx, btb_wr_idx, mp_lru_idx;
   btb_entry_t rd_way0, rd_way1, btb_wr_entry;
   logic       rd_lru, hit_en, hit_way0;
   logic       btb_wr_en, btb_wr_way, mp_lru_en, mp_lru_way;
   bht_idx_t   bht_rd_idx, bht_mp_idx, bht_br_idx;
   logic       bht_mp_en, bht_br_en;
   ctr_t       rd_ctr;
   logic       rs_push, rs_pop, rs_top_valid;
   pc_t        rs_push_addr, rs_top;

   btb_array btb_array_inst (
      .*,
      .rd_idx   (btb_rd_idx),
      .wr_en    (btb_wr_en),
      .wr_way   (btb_wr_way),
      .wr_idx   (btb_wr_idx),
      .wr_entry (btb_wr_entry)
   );

   bht_array bht_array_inst (
      .*,
      .rd_idx (bht_rd_idx),
      .mp_en  (bht_mp_en),
      .mp_idx (bht_mp_idx),
      .mp_ctr (mp_hist),     // counter values come straight from the ports
      .br_en  (bht_br_en),
      .br_idx (bht_br_idx),
      .br_ctr (br_hist)
   );

   return_stack return_stack_inst (
      .*,
      .push      (rs_push),
      .pop       (rs_pop),
      .push_addr (rs_push_addr),
      .top_addr  (rs_top),
      .top_valid (rs_top_valid)
   );

   bp_predict bp_predict_inst (.*);

   bp_update bp_update_inst (.*);

endmodule

/* source/btb_array.sv */
`timescale 1ns/1ps

module btb_array
   import bp_cfg_pkg::*;
   import bp_entry_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  btb_idx_t   rd_idx,
   input  logic       wr_en,
   input  logic       wr_way,
   input  btb_idx_t   wr_idx,
   input  btb_entry_t wr_entry,
   input  logic       hit_en,
   input  logic       hit_way0,
   input  logic       mp_lru_en,
   input  btb_idx_t   mp_lru_idx,
   input  logic       mp_lru_way,
   output btb_entry_t rd_way0,
   output btb_entry_t rd_way1,
   output logic       rd_lru
);

   btb_entry_t          mem_q [2][BTB_SETS];  // [way][set]
   logic [BTB_SETS-1:0] vld_q [2];
   logic [BTB_SETS-1:0] lru_q;                // names the way to replace

   // --------------------------------------------------
   // storage
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem_q[wr_way][wr_idx] <= wr_entry;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld_q[0] <= '0;
         vld_q[1] <= '0;
      end else if (wr_en) begin
         vld_q[wr_way][wr_idx] <= wr_entry[E_VALID]; // 0 on error invalidate
      end
   end

   // fetch hit points away from the hit way, mispredict written last so it wins
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lru_q <= '0;
      end else begin
         if (hit_en) begin
            lru_q[rd_idx] <= hit_way0;
         end
         if (mp_lru_en) begin
            lru_q[mp_lru_idx] <= ~mp_lru_way;
         end
      end
   end

   // --------------------------------------------------
   // read mux
   // --------------------------------------------------
   always_comb begin
      rd_way0          = mem_q[0][rd_idx];
      rd_way0[E_VALID] = vld_q[0][rd_idx];
      rd_way1          = mem_q[1][rd_idx];
      rd_way1[E_VALID] = vld_q[1][rd_idx];
   end

   assign rd_lru = lru_q[rd_idx];

endmodule

/* source/return_stack.sv */
`timescale 1ns/1ps

module return_stack
   import bp_cfg_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic push,
   input  logic pop,
   input  pc_t  push_addr,
   output pc_t  top_addr,
   output logic top_valid
);

   pc_t                 addr_q [RS_DEPTH];
   logic [RS_DEPTH-1:0] vld_q;

   // return address shift register
   always_ff @(posedge clk) begin
      if (push) begin
         addr_q[0] <= push_addr;
         for (int i = 1; i < RS_DEPTH; i++) begin
            addr_q[i] <= addr_q[i-1];   // bottom entry falls off
         end
      end else if (pop) begin
         for (int i = 0; i < RS_DEPTH-1; i++) begin
            addr_q[i] <= addr_q[i+1];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld_q <= '0;
      end else if (push) begin
         vld_q <= {vld_q[RS_DEPTH-2:0], 1'b1};
      end else if (pop) begin
         vld_q <= {1'b0, vld_q[RS_DEPTH-1:1]};
      end
   end

   assign top_addr  = addr_q[0];
   assign top_valid = vld_q[0];

endmodule

/* verification/tb_checks.svh */
// --------------------------------------------------
// stop the run at the first failure
// --------------------------------------------------
task automatic abort_run(input string why);
   $display("%s", why);
   $display("Test FAILED");
   $fatal(1, "simulation stopped");
endtask

task automatic check_pc(input string name, input pc_t exp, input pc_t act);
   if (exp !== act) begin
      abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
   end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
   if (exp !== act) begin
      abort_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
   end
endtask

task automatic check_ctr(input string name, input ctr_t exp, input ctr_t act);
   if (exp !== act) begin
      abort_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
   end
endtask

task automatic check_ghr(input string name, input ghr_t exp, input ghr_t act);
   if (exp !== act) begin
      abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
   end
endtask

// bounded wait for the end of reset
task automatic wait_reset_release(input int max_cycles);
   int n;
   n = 0;
   while (!rst_n && n < max_cycles) begin
      @(posedge clk);
      n++;
   end
   if (!rst_n) begin
      abort_run("reset was never released");
   end
endtask

/* verification/branch_predictor_tb.sv */
`timescale 1ns/1ps

module branch_predictor_tb
   import bp_cfg_pkg::*;
   import bp_entry_pkg::*;
;

   typedef enum logic [2:0] {OP_FETCH, OP_MP, OP_COMMIT, OP_BOTH, OP_FLUSH} op_e;

   typedef struct packed {
      op_e   op;
      pc_t   pc;
      toff_t toff;
      logic  way;     // write way, or expected bp_way on a fetch
      ctr_t  hist;    // commit counter, or mispredict counter alone
      ctr_t  hist2;   // mispredict counter in a shared cycle
      logic  call;
      logic  ret;
      logic  pc4;
      logic  err;
      logic  dis;
      logic  hit;     // fetch expected to hit
      ghr_t  ghr;
   } row_t;

   logic clk, rst_n;
   logic fetch_req, ic_hit;
   pc_t fetch_addr;
   logic mp_valid, mp_ataken, mp_way, mp_pc4, mp_call, mp_ret, mp_ja;
   pc_t mp_pc;
   ghr_t mp_fghr;
   ctr_t mp_hist;
   toff_t mp_toffset;
   logic br_valid, br_way, br_error;
   pc_t br_pc;
   ghr_t br_fghr;
   ctr_t br_hist;
   logic flush, bpred_disable;
   ghr_t flush_ghr;
   logic bp_hit_taken, bp_valid, bp_way, bp_ret;
   pc_t bp_target;
   ctr_t bp_hist;
   ghr_t bp_fghr;

   row_t rows[$];
   ctr_t ctr_ref [BHT_DEPTH];
   pc_t rs_ref[$];
   ghr_t ghr_ref;
   integer seed;

   tb_clock_gen tb_clock_gen_inst (.clk(clk), .rst_n(rst_n));

   branch_predictor branch_predictor_inst (.*);

   `include "tb_checks.svh"

   // --------------------------------------------------
   // reference helpers
   // --------------------------------------------------
   function automatic bht_idx_t gshare_idx(input pc_t pc, input ghr_t ghr);
      logic [BTB_IDX_W-1:0] set;
      set = pc[3:0] ^ pc[7:4] ^ pc[11:8];
      return {{(GHR_W-BTB_IDX_W){1'b0}}, set} ^ ghr;
   endfunction

   function automatic pc_t add_offset(input pc_t pc, input toff_t t);
      return pc + {{(PC_W-TOFF_W){t[TOFF_W-1]}}, t};
   endfunction

   task automatic add_fetch(input pc_t pc, input logic hit, input logic way, input toff_t toff,
                            input logic call, input logic ret, input logic pc4, input logic dis);
      row_t r;
      r = '0;
      r.op = OP_FETCH;
      r.pc = pc;
      r.hit = hit;
      r.way = way;
      r.toff = toff;
      r.call = call;
      r.ret = ret;
      r.pc4 = pc4;
      r.dis = dis;
      rows.push_back(r);
   endtask

   task automatic add_mispredict(input pc_t pc, input toff_t toff, input logic way,
                                 input ctr_t hist, input logic call, input logic ret,
                                 input logic pc4);
      row_t r;
      r = '0;
      r.op = OP_MP;
      r.pc = pc;
      r.toff = toff;
      r.way = way;
      r.hist2 = hist;
      r.call = call;
      r.ret = ret;
      r.pc4 = pc4;
      rows.push_back(r);
   endtask

   task automatic add_commit(input op_e op, input pc_t pc, input logic way, input ctr_t hist,
                             input ctr_t mp_h, input toff_t toff, input logic err);
      row_t r;
      r = '0;
      r.op = op;
      r.pc = pc;
      r.way = way;
      r.hist = hist;
      r.hist2 = mp_h;
      r.toff = toff;
      r.err = err;
      rows.push_back(r);
   endtask

   task automatic add_flush(input ghr_t ghr);
      row_t r;
      r = '0;
      r.op = OP_FLUSH;
      r.ghr = ghr;
      rows.push_back(r);
   endtask

   task automatic idle_inputs();
      fetch_req = 0;
      ic_hit = 0;
      fetch_addr = '0;
      mp_valid = 0;
      mp_ataken = 0;
      mp_pc = '0;
      mp_fghr = '0;
      mp_way = 0;
      mp_hist = '0;
      mp_toffset = '0;
      mp_pc4 = 0;
      mp_call = 0;
      mp_ret = 0;
      mp_ja = 0;
      br_valid = 0;
      br_pc = '0;
      br_fghr = '0;
      br_hist = '0;
      br_way = 0;
      br_error = 0;
      flush = 0;
      flush_ghr = '0;
      bpred_disable = 0;
   endtask

   // --------------------------------------------------
   // stimulus table and run loop
   // --------------------------------------------------
   initial begin
      pc_t a_pc, c_pc, r_pc, e_target;
      logic e_valid, e_taken, e_ret, is_ret;
      bht_idx_t ix;
      string tag;

      idle_inputs();
      seed = 32;
      a_pc = 31'h0000_0124;   // set 7
      c_pc = 31'h0000_0040;   // set 4
      r_pc = 31'h0000_0300;   // set 3
      for (int i = 0; i < BHT_DEPTH; i++) begin
         ctr_ref[i] = '0;
      end
      ghr_ref = '0;

      repeat (4) add_fetch(pc_t'($random(seed)), 0, 0, '0, 0, 0, 0, 0);   // empty table
      add_flush(6'h00);
      add_mispredict(a_pc, 12'h010, 0, 2'b11, 0, 0, 0);
      add_fetch(a_pc, 1, 0, 12'h010, 0, 0, 0, 1);          // predictor disabled
      add_fetch(a_pc, 1, 0, 12'h010, 0, 0, 0, 0);
      add_flush(6'h00);
      add_commit(OP_BOTH, a_pc, 0, 2'b01, 2'b11, 12'h010, 0); // commit beats mispredict
      add_fetch(a_pc, 1, 0, 12'h010, 0, 0, 0, 0);
      add_mispredict(c_pc, 12'h020, 1, 2'b11, 1, 0, 1);     // 4-byte call
      add_fetch(c_pc, 1, 1, 12'h020, 1, 0, 1, 0);
      add_mispredict(r_pc, 12'h004, 0, 2'b11, 0, 1, 0);     // return
      add_fetch(r_pc, 1, 0, 12'h004, 0, 1, 0, 0);
      add_commit(OP_COMMIT, a_pc, 0, 2'b11, 2'b00, '0, 1);   // error invalidate
      add_fetch(a_pc, 0, 1, '0, 0, 0, 0, 0);                 // lru[7] is 1
      add_mispredict(a_pc, 12'h010, 1, 2'b11, 0, 0, 0);
      add_fetch(a_pc, 1, 1, 12'h010, 0, 0, 0, 0);
      add_flush(6'h2a);
      add_fetch(31'h0000_0555, 0, 0, '0, 0, 0, 0, 0);

      wait_reset_release(20);
      @(posedge clk);
      #1;

      foreach (rows[i]) begin
         tag = $sformatf("row %0d", i);
         idle_inputs();
         case (rows[i].op)
            OP_FETCH: begin
               fetch_req = 1;
               ic_hit = 1;
               fetch_addr = rows[i].pc;
               bpred_disable = rows[i].dis;
            end
            OP_FLUSH: begin
               flush = 1;
               flush_ghr = rows[i].ghr;
            end
            default: ;
         endcase
         if (rows[i].op == OP_MP || rows[i].op == OP_BOTH) begin
            mp_valid = 1;
            mp_ataken = 1;
            mp_pc = rows[i].pc;
            mp_fghr = ghr_ref;
            mp_way = rows[i].way;
            mp_hist = rows[i].hist2;
            mp_toffset = rows[i].toff;
            mp_pc4 = rows[i].pc4;
            mp_call = rows[i].call;
            mp_ret = rows[i].ret;
         end
         if (rows[i].op == OP_COMMIT || rows[i].op == OP_BOTH) begin
            br_valid = 1;
            br_pc = rows[i].pc;
            br_fghr = ghr_ref;
            br_hist = rows[i].hist;
            br_way = rows[i].way;
            br_error = rows[i].err;
         end

         #4;   // sample in mid cycle
         check_ghr({tag, " bp_fghr"}, ghr_ref, bp_fghr);
         ix = gshare_idx(rows[i].pc, ghr_ref);
         if (rows[i].op == OP_FETCH) begin
            is_ret = rows[i].ret & ~rows[i].call;
            e_valid = rows[i].hit & ~rows[i].dis;
            e_taken = e_valid & (ctr_ref[ix][1] | rows[i].call | rows[i].ret);
            e_ret = rows[i].hit & is_ret;
            e_target = (is_ret && rs_ref.size() > 0) ? rs_ref[0] :
                       add_offset(rows[i].pc, rows[i].toff);
            check_bit({tag, " bp_valid"}, e_valid, bp_valid);
            check_bit({tag, " bp_hit_taken"}, e_taken, bp_hit_taken);
            check_bit({tag, " bp_way"}, rows[i].way, bp_way);
            check_bit({tag, " bp_ret"}, e_ret, bp_ret);
            check_ctr({tag, " bp_hist"}, ctr_ref[ix], bp_hist);
            check_pc({tag, " bp_target"}, e_target, bp_target);
            // model state that changes at the edge
            if (e_taken && rows[i].call && !rows[i].ret) begin
               rs_ref.push_front(rows[i].pc + (rows[i].pc4 ? pc_t'(2) : pc_t'(1)));
               if (rs_ref.size() > RS_DEPTH) begin
                  void'(rs_ref.pop_back());
               end
            end else if (e_taken && is_ret && rs_ref.size() > 0) begin
               void'(rs_ref.pop_front());
            end
            if (e_valid) begin
               ghr_ref = {ghr_ref[GHR_W-2:0], e_taken};
            end
         end else begin
            check_bit({tag, " bp_valid idle"}, 1'b0, bp_valid);
            if ((rows[i].op == OP_MP || rows[i].op == OP_BOTH) &&
                !rows[i].call && !rows[i].ret) begin
               ctr_ref[ix] = rows[i].hist2;
            end
            if (rows[i].op == OP_COMMIT || rows[i].op == OP_BOTH) begin
               ctr_ref[ix] = rows[i].hist;   // commit lands last
            end
            if (rows[i].op == OP_FLUSH) begin
               ghr_ref = rows[i].ghr;
            end
         end
         @(posedge clk);
         #1;
      end

      // the flush row before the last fetch shows up here
      check_ghr("final bp_fghr", ghr_ref, bp_fghr);
      $display("Test OK");
      $finish;
   end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   initial begin
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      #1 rst_n = 1'b1;
   end

endmodule
